/* verilog/xgmii_tx_pkg.sv */
// shared types, xgmii characters and crc helpers for the axi-stream to xgmii transmitter
package xgmii_tx_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    typedef logic [63:0] xgmii_data_t;   // 8 lanes with lane 0 in the low byte
    typedef logic [7:0]  xgmii_ctrl_t;   // one control bit per lane
    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_keep_t;
    typedef logic [31:0] crc_t;
    typedef logic [3:0]  byte_cnt_t;     // valid bytes in the last beat, 1..8

    typedef enum logic [2:0] {
        st_idle,    // waiting for a frame
        st_data,    // streaming beats
        st_tail,    // final data word
        st_term,    // terminate word
        st_gap      // forced idle word
    } tx_state_e;

    // ------------------------------
    // xgmii characters
    // ------------------------------
    localparam logic [7:0] xgmii_idle   = 8'h07;
    localparam logic [7:0] xgmii_start  = 8'hfb;
    localparam logic [7:0] xgmii_term   = 8'hfd;
    localparam logic [7:0] xgmii_error  = 8'hfe;
    localparam logic [7:0] eth_preamble = 8'h55;
    localparam logic [7:0] eth_sfd      = 8'hd5;

    // whole words
    localparam xgmii_data_t idle_word_d  = {8{xgmii_idle}};
    localparam xgmii_ctrl_t idle_word_c  = 8'hff;
    localparam xgmii_data_t start_word_d = {eth_sfd, {6{eth_preamble}}, xgmii_start};
    localparam xgmii_ctrl_t start_word_c = 8'h01;
    localparam xgmii_ctrl_t err_word_c   = 8'h81;  // error in lane 0, terminate in lane 7

    // ------------------------------
    // crc-32 of ieee 802.3
    // ------------------------------
    localparam crc_t crc_preset = 32'hffff_ffff;
    localparam crc_t crc_poly   = 32'hedb8_8320;  // reflected form

    // one byte into the crc with lsb first as sent on the wire
    function automatic crc_t crc32_byte(crc_t crc, logic [7:0] b);
        crc_t c;
        c = crc ^ {24'h0, b};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // swaps bit order of a crc word
    function automatic crc_t crc_rev(crc_t crc);
        crc_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = crc[31-i];
        end
        return r;
    endfunction

endpackage

/* verilog/crc32_d64.sv */
// running crc-32 over 64-bit beats, keeps partial results for 1 to 8 leading bytes
module crc32_d64 (
    input  logic                     clk,
    input  logic                     rst,
    input  xgmii_tx_pkg::beat_data_t beat_i,
    input  logic                     beat_en_i,
    input  logic                     clear_i,
    input  xgmii_tx_pkg::byte_cnt_t  cnt_i,
    output xgmii_tx_pkg::crc_t       fcs_o
);

    // registers hold the crc msb-first while the byte update runs lsb-first
    xgmii_tx_pkg::crc_t run_q;          // crc over all full beats so far
    xgmii_tx_pkg::crc_t part_q [8];     // part_q[i] covers bytes 0..i of last beat
    xgmii_tx_pkg::crc_t chain  [9];
    logic [2:0]         sel;

    // ------------------------------
    // byte chain across the beat
    // ------------------------------
    always_comb begin
        chain[0] = xgmii_tx_pkg::crc_rev(run_q);
        for (int i = 0; i < 8; i++) begin
            chain[i+1] = xgmii_tx_pkg::crc32_byte(chain[i], beat_i[8*i +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= xgmii_tx_pkg::crc_preset;
        end else if (clear_i) begin
            run_q <= xgmii_tx_pkg::crc_preset;   // ready for next frame
        end else if (beat_en_i) begin
            run_q <= xgmii_tx_pkg::crc_rev(chain[8]);
        end
    end

    // candidates for every possible last-beat length
    always_ff @(posedge clk) begin
        if (beat_en_i) begin
            for (int i = 0; i < 8; i++) begin
                part_q[i] <= xgmii_tx_pkg::crc_rev(chain[i+1]);
            end
        end
    end

    // ------------------------------
    // fcs select
    // ------------------------------
    // count 8 wraps to index 7
    assign sel   = cnt_i[2:0] - 3'd1;
    assign fcs_o = ~xgmii_tx_pkg::crc_rev(part_q[sel]);   // byte 0 goes out first

    // the controller clears the crc in the cycle the fcs is taken
    a_cnt_nonzero: assert property (@(posedge clk) disable iff (rst)
        clear_i |-> (cnt_i inside {[4'd1:4'd8]}));

endmodule

/* verilog/xgmii_tail_pack.sv */
// packs the last beat, fcs and terminate into the tail and terminate words
module xgmii_tail_pack (
    input  xgmii_tx_pkg::beat_data_t  beat_i,
    input  xgmii_tx_pkg::byte_cnt_t   cnt_i,
    input  xgmii_tx_pkg::crc_t        fcs_i,
    output xgmii_tx_pkg::xgmii_data_t tail_d_o,
    output xgmii_tx_pkg::xgmii_ctrl_t tail_c_o,
    output xgmii_tx_pkg::xgmii_data_t term_d_o,
    output xgmii_tx_pkg::xgmii_ctrl_t term_c_o
);

    // byte order across the two words is data, fcs, terminate, idles
    always_comb begin
        tail_d_o = xgmii_tx_pkg::idle_word_d;
        tail_c_o = xgmii_tx_pkg::idle_word_c;
        term_d_o = xgmii_tx_pkg::idle_word_d;
        term_c_o = xgmii_tx_pkg::idle_word_c;

        case (cnt_i)
            4'd8: begin
                tail_d_o = beat_i;
                tail_c_o = 8'h00;
                term_d_o = {{3{xgmii_tx_pkg::xgmii_idle}}, xgmii_tx_pkg::xgmii_term, fcs_i};
                term_c_o = 8'hf0;
            end
            4'd7: begin
                tail_d_o = {fcs_i[7:0], beat_i[55:0]};
                tail_c_o = 8'h00;
                term_d_o = {{4{xgmii_tx_pkg::xgmii_idle}}, xgmii_tx_pkg::xgmii_term,
                            fcs_i[31:8]};
                term_c_o = 8'hf8;
            end
            4'd6: begin
                tail_d_o = {fcs_i[15:0], beat_i[47:0]};
                tail_c_o = 8'h00;
                term_d_o = {{5{xgmii_tx_pkg::xgmii_idle}}, xgmii_tx_pkg::xgmii_term,
                            fcs_i[31:16]};
                term_c_o = 8'hfc;
            end
            4'd5: begin
                tail_d_o = {fcs_i[23:0], beat_i[39:0]};
                tail_c_o = 8'h00;
                term_d_o = {{6{xgmii_tx_pkg::xgmii_idle}}, xgmii_tx_pkg::xgmii_term,
                            fcs_i[31:24]};
                term_c_o = 8'hfe;
            end
            4'd4: begin
                tail_d_o = {fcs_i, beat_i[31:0]};
                tail_c_o = 8'h00;
                term_d_o = {{7{xgmii_tx_pkg::xgmii_idle}}, xgmii_tx_pkg::xgmii_term};
                term_c_o = 8'hff;   // terminate alone in lane 0
            end
            // short tails carry terminate in the tail word and leave the second word idle
            4'd3: begin
                tail_d_o = {xgmii_tx_pkg::xgmii_term, fcs_i, beat_i[23:0]};
                tail_c_o = 8'h80;
            end
            4'd2: begin
                tail_d_o = {xgmii_tx_pkg::xgmii_idle, xgmii_tx_pkg::xgmii_term,
                            fcs_i, beat_i[15:0]};
                tail_c_o = 8'hc0;
            end
            4'd1: begin
                tail_d_o = {{2{xgmii_tx_pkg::xgmii_idle}}, xgmii_tx_pkg::xgmii_term,
                            fcs_i, beat_i[7:0]};
                tail_c_o = 8'he0;
            end
            default: begin
                tail_c_o = xgmii_tx_pkg::idle_word_c;   // no valid count leaves both idle
            end
        endcase
    end

endmodule

/* verilog/tx_frame_ctrl.sv */
// frame controller for stream handshake, beat holding and xgmii word selection
module tx_frame_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  xgmii_tx_pkg::beat_data_t  tdata_i,
    input  xgmii_tx_pkg::beat_keep_t  tkeep_i,
    input  logic                      tvalid_i,
    input  logic                      tlast_i,
    input  logic                      tuser_i,
    input  xgmii_tx_pkg::crc_t        fcs_i,
    input  xgmii_tx_pkg::xgmii_data_t tail_d_i,
    input  xgmii_tx_pkg::xgmii_ctrl_t tail_c_i,
    input  xgmii_tx_pkg::xgmii_data_t term_d_i,
    input  xgmii_tx_pkg::xgmii_ctrl_t term_c_i,
    output logic                      tready_o,
    output xgmii_tx_pkg::beat_data_t  beat_o,
    output logic                      beat_en_o,
    output logic                      clear_o,
    output xgmii_tx_pkg::byte_cnt_t   cnt_o,
    output xgmii_tx_pkg::xgmii_data_t xgmii_d_o,
    output xgmii_tx_pkg::xgmii_ctrl_t xgmii_c_o
);

    xgmii_tx_pkg::tx_state_e   state_q;
    xgmii_tx_pkg::beat_data_t  hold_q;     // beat waiting for its output slot
    xgmii_tx_pkg::beat_keep_t  keep_q;
    logic                      err_q;      // held beat carried tuser
    logic                      tready_q;
    xgmii_tx_pkg::xgmii_data_t xd_q;
    xgmii_tx_pkg::xgmii_ctrl_t xc_q;
    logic                      accept;
    xgmii_tx_pkg::byte_cnt_t   cnt;
    xgmii_tx_pkg::xgmii_data_t err_d;

    assign accept = tvalid_i & tready_q;

    // keep is contiguous from lane 0, so a popcount gives the length
    always_comb begin
        cnt = '0;
        for (int i = 0; i < 8; i++) begin
            cnt = cnt + xgmii_tx_pkg::byte_cnt_t'(keep_q[i]);
        end
    end

    // error in lane 0, terminate in lane 7, beat bytes in between
    assign err_d = {xgmii_tx_pkg::xgmii_term, hold_q[55:8], xgmii_tx_pkg::xgmii_error};

    // ------------------------------
    // beat holding register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_q <= tdata_i;
            keep_q <= tkeep_i;
        end
    end

    // ------------------------------
    // frame fsm and output words
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= xgmii_tx_pkg::st_gap;   // raises tready one cycle later
            tready_q <= 1'b0;
            err_q    <= 1'b0;
            xd_q     <= xgmii_tx_pkg::idle_word_d;
            xc_q     <= xgmii_tx_pkg::idle_word_c;
        end else begin
            if (accept) begin
                err_q <= tuser_i;
                if (tlast_i) begin
                    tready_q <= 1'b0;   // closed until the gap word is out
                end
            end

            case (state_q)
                xgmii_tx_pkg::st_idle: begin
                    xd_q <= xgmii_tx_pkg::idle_word_d;
                    xc_q <= xgmii_tx_pkg::idle_word_c;
                    if (accept) begin
                        xd_q    <= xgmii_tx_pkg::start_word_d;
                        xc_q    <= xgmii_tx_pkg::start_word_c;
                        state_q <= tlast_i ? xgmii_tx_pkg::st_tail : xgmii_tx_pkg::st_data;
                    end
                end
                xgmii_tx_pkg::st_data: begin
                    xd_q <= hold_q;   // one beat behind the input
                    xc_q <= 8'h00;
                    if (accept && tlast_i) begin
                        state_q <= xgmii_tx_pkg::st_tail;
                    end
                end
                xgmii_tx_pkg::st_tail: begin
                    if (err_q) begin
                        xd_q    <= err_d;
                        xc_q    <= xgmii_tx_pkg::err_word_c;
                        state_q <= xgmii_tx_pkg::st_gap;   // no fcs on an aborted frame
                    end else begin
                        xd_q <= tail_d_i;
                        xc_q <= tail_c_i;
                        if (cnt < 4'd4) begin
                            state_q <= xgmii_tx_pkg::st_gap;   // terminate already sent
                        end else begin
                            state_q <= xgmii_tx_pkg::st_term;
                        end
                    end
                end
                xgmii_tx_pkg::st_term: begin
                    xd_q    <= term_d_i;
                    xc_q    <= term_c_i;
                    state_q <= xgmii_tx_pkg::st_gap;
                end
                xgmii_tx_pkg::st_gap: begin
                    xd_q     <= xgmii_tx_pkg::idle_word_d;
                    xc_q     <= xgmii_tx_pkg::idle_word_c;
                    tready_q <= 1'b1;
                    state_q  <= xgmii_tx_pkg::st_idle;
                end
                default: begin
                    tready_q <= 1'b0;
                    state_q  <= xgmii_tx_pkg::st_gap;
                end
            endcase
        end
    end

    assign tready_o  = tready_q;
    assign beat_o    = hold_q;
    assign beat_en_o = accept;
    assign clear_o   = (state_q == xgmii_tx_pkg::st_tail);   // fcs taken this cycle
    assign cnt_o     = cnt;
    assign xgmii_d_o = xd_q;
    assign xgmii_c_o = xc_q;

    // ------------------------------
    // source protocol
    // ------------------------------
    a_keep_contig: assert property (@(posedge clk) disable iff (rst)
        accept && tlast_i |-> (tkeep_i inside {8'h01, 8'h03, 8'h07, 8'h0f,
                                               8'h1f, 8'h3f, 8'h7f, 8'hff}));

    // no bubbles between the first and last beat
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        accept && !tlast_i |=> tvalid_i);

endmodule

/* verilog/axis_xgmii_tx.sv */
// axi-stream to xgmii transmit adapter with crc-32 fcs insertion
module axis_xgmii_tx (
    input  logic                      clk,
    input  logic                      rst,
    input  xgmii_tx_pkg::beat_data_t  tdata_i,
    input  xgmii_tx_pkg::beat_keep_t  tkeep_i,
    input  logic                      tvalid_i,
    input  logic                      tlast_i,
    input  logic                      tuser_i,
    output logic                      tready_o,
    output xgmii_tx_pkg::xgmii_data_t xgmii_d_o,
    output xgmii_tx_pkg::xgmii_ctrl_t xgmii_c_o
);

    xgmii_tx_pkg::beat_data_t  beat_held;
    logic                      beat_en;
    logic                      clear;
    xgmii_tx_pkg::byte_cnt_t   cnt;
    xgmii_tx_pkg::crc_t        fcs;
    xgmii_tx_pkg::xgmii_data_t tail_d;
    xgmii_tx_pkg::xgmii_ctrl_t tail_c;
    xgmii_tx_pkg::xgmii_data_t term_d;
    xgmii_tx_pkg::xgmii_ctrl_t term_c;

    tx_frame_ctrl ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .tdata_i   (tdata_i),
        .tkeep_i   (tkeep_i),
        .tvalid_i  (tvalid_i),
        .tlast_i   (tlast_i),
        .tuser_i   (tuser_i),
        .fcs_i     (fcs),
        .tail_d_i  (tail_d),
        .tail_c_i  (tail_c),
        .term_d_i  (term_d),
        .term_c_i  (term_c),
        .tready_o  (tready_o),
        .beat_o    (beat_held),
        .beat_en_o (beat_en),
        .clear_o   (clear),
        .cnt_o     (cnt),
        .xgmii_d_o (xgmii_d_o),
        .xgmii_c_o (xgmii_c_o)
    );

    // crc sees each beat in the cycle it is accepted
    crc32_d64 crc0 (
        .clk       (clk),
        .rst       (rst),
        .beat_i    (tdata_i),
        .beat_en_i (beat_en),
        .clear_i   (clear),
        .cnt_i     (cnt),
        .fcs_o     (fcs)
    );

    xgmii_tail_pack tail0 (
        .beat_i   (beat_held),
        .cnt_i    (cnt),
        .fcs_i    (fcs),
        .tail_d_o (tail_d),
        .tail_c_o (tail_c),
        .term_d_o (term_d),
        .term_c_o (term_c)
    );

endmodule

/* sim/tb_axis_xgmii_tx.sv */
// self-checking testbench for the axi-stream to xgmii transmit adapter
module tb_axis_xgmii_tx;

    localparam logic [31:0] default_seed = 32'ha4e7632f;
    localparam logic [71:0] idle_w = {8'hff, {8{xgmii_tx_pkg::xgmii_idle}}};  // {ctrl, data}

    logic                      clk;
    logic                      rst;
    xgmii_tx_pkg::beat_data_t  tdata;
    xgmii_tx_pkg::beat_keep_t  tkeep;
    logic                      tvalid;
    logic                      tlast;
    logic                      tuser;
    logic                      tready;
    xgmii_tx_pkg::xgmii_data_t xgmii_d;
    xgmii_tx_pkg::xgmii_ctrl_t xgmii_c;

    // beats still to send, words still to see
    xgmii_tx_pkg::beat_data_t  tx_d [$];
    xgmii_tx_pkg::beat_keep_t  tx_k [$];
    logic                      tx_l [$];
    logic                      tx_u [$];
    logic [71:0]               exp_w [$];

    int total_beats = 0;
    int n_frames    = 0;
    int cycle_limit = 1000000;
    int checks      = 0;
    int mismatches  = 0;
    int other_errs  = 0;
    int frames_out  = 0;
    int idle_run    = 0;   // idle words since the last frame word

    axis_xgmii_tx dut0 (
        .clk       (clk),
        .rst       (rst),
        .tdata_i   (tdata),
        .tkeep_i   (tkeep),
        .tvalid_i  (tvalid),
        .tlast_i   (tlast),
        .tuser_i   (tuser),
        .tready_o  (tready),
        .xgmii_d_o (xgmii_d),
        .xgmii_c_o (xgmii_c)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_equal(input logic [71:0] got, input logic [71:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run;
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    task automatic build_frame(input int len, input int err, input logic [31:0] seed);
        logic [31:0]              st;
        xgmii_tx_pkg::crc_t       crc;
        xgmii_tx_pkg::crc_t       fcs;
        logic [7:0]               fb [$];
        logic [7:0]               lane_b [$];
        logic                     lane_c [$];
        xgmii_tx_pkg::beat_data_t d;
        xgmii_tx_pkg::beat_keep_t k;
        logic [71:0]              w;
        int                       nb;
        st  = (seed == 32'h0) ? default_seed : seed;
        crc = xgmii_tx_pkg::crc_preset;
        for (int i = 0; i < len; i++) begin
            st = lcg_next(st);
            fb.push_back(st[31:24]);
            crc = xgmii_tx_pkg::crc32_byte(crc, st[31:24]);
        end
        nb = (len + 7) / 8;
        exp_w.push_back({8'h01, xgmii_tx_pkg::eth_sfd, {6{xgmii_tx_pkg::eth_preamble}},
                         xgmii_tx_pkg::xgmii_start});
        for (int b = 0; b < nb; b++) begin
            d = '0;   // lanes past the frame end stay zero
            k = '0;
            for (int l = 0; l < 8; l++) begin
                if (8*b + l < len) begin
                    d[8*l +: 8] = fb[8*b + l];
                    k[l] = 1'b1;
                end
            end
            tx_d.push_back(d);
            tx_k.push_back(k);
            tx_l.push_back(b == nb - 1);
            tx_u.push_back(err != 0 && b == nb - 1);
            if (err != 0 && b < nb - 1) begin
                exp_w.push_back({8'h00, d});
            end else if (err != 0) begin
                // aborted frame ends with error in lane 0 and terminate in lane 7
                exp_w.push_back({8'h81, xgmii_tx_pkg::xgmii_term, d[55:8],
                                 xgmii_tx_pkg::xgmii_error});
            end
        end
        if (err == 0) begin
            fcs = ~crc;
            foreach (fb[i]) begin
                lane_b.push_back(fb[i]);
                lane_c.push_back(1'b0);
            end
            for (int i = 0; i < 4; i++) begin
                lane_b.push_back(fcs[8*i +: 8]);   // low byte goes out first
                lane_c.push_back(1'b0);
            end
            lane_b.push_back(xgmii_tx_pkg::xgmii_term);
            lane_c.push_back(1'b1);
            while (lane_b.size() % 8 != 0) begin
                lane_b.push_back(xgmii_tx_pkg::xgmii_idle);
                lane_c.push_back(1'b1);
            end
            for (int i = 0; i < lane_b.size(); i += 8) begin
                for (int l = 0; l < 8; l++) begin
                    w[8*l +: 8] = lane_b[i + l];
                    w[64 + l]   = lane_c[i + l];
                end
                exp_w.push_back(w);
            end
        end
        total_beats += nb;
        n_frames++;
    endtask

    // drive one beat and hold it until accepted
    task automatic send_beat;
        tdata  <= tx_d.pop_front();
        tkeep  <= tx_k.pop_front();
        tlast  <= tx_l.pop_front();
        tuser  <= tx_u.pop_front();
        tvalid <= 1'b1;
        @(negedge clk);
        while (tready !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);   // accepted here
    endtask

    // ------------------------------
    // output monitor
    // ------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            if ({xgmii_c, xgmii_d} === idle_w) begin
                idle_run++;
            end else begin
                if (xgmii_c == 8'h01 && xgmii_d[7:0] == xgmii_tx_pkg::xgmii_start) begin
                    if (frames_out > 0 && idle_run == 0) begin
                        $display("frame %0d started with no idle word before it", frames_out);
                        other_errs++;
                    end
                    frames_out++;
                end
                idle_run = 0;
                if (exp_w.size() == 0) begin
                    $display("unexpected word %h %h on xgmii at %0t", xgmii_c, xgmii_d, $time);
                    other_errs++;
                end else begin
                    check_equal({xgmii_c, xgmii_d}, exp_w.pop_front(), "xgmii word");
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        other_errs++;
        finish_run();
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int          fd;
        int          rc;
        int          len;
        int          err;
        logic [31:0] seed;
        string       line;
        rst    = 1'b1;
        tdata  = '0;
        tkeep  = '0;
        tvalid = 1'b0;
        tlast  = 1'b0;
        tuser  = 1'b0;
        fd = $fopen("sim/tx_frame_cases.txt", "r");
        if (fd == 0) begin
            $display("case file sim/tx_frame_cases.txt could not be opened");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && $sscanf(line, "%d %d %h", len, err, seed) == 3) begin
                    build_frame(len, err, seed);
                end
            end
            $fclose(fd);
        end
        if (n_frames == 0) begin
            $display("no frames were read from the case file");
            other_errs++;
        end
        cycle_limit = 10 * total_beats + 200;

        @(posedge clk);
        @(negedge clk);
        check_equal({xgmii_c, xgmii_d}, idle_w, "xgmii in reset");
        check_equal(72'(tready), 72'd0, "tready in reset");
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal({xgmii_c, xgmii_d}, idle_w, "xgmii after reset");
        check_equal(72'(tready), 72'd0, "tready after reset");
        @(posedge clk);
        @(negedge clk);
        check_equal(72'(tready), 72'd1, "tready open");
        @(posedge clk);

        while (tx_d.size() > 0) begin
            send_beat();
        end
        tvalid <= 1'b0;
        tlast  <= 1'b0;
        tuser  <= 1'b0;
        while (exp_w.size() > 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // trailing words must all be idle
        check_equal(72'(frames_out), 72'(n_frames), "frame count");
        finish_run();
    end

endmodule

/* sim/tx_frame_cases.txt */
# columns: frame length in bytes, error flag (1 aborts on the last beat), data seed in hex
# a seed of 0 picks the default seed
1 0 00000000
2 0 00000000
3 0 00000000
4 0 00000000
5 0 00000000
6 0 00000000
7 0 00000000
8 0 00000000
9 0 1f2e3d4c
10 0 1f2e3d4c
11 0 1f2e3d4c
12 0 1f2e3d4c
13 0 1f2e3d4c
14 0 1f2e3d4c
15 0 1f2e3d4c
16 0 1f2e3d4c
60 0 00c0ffee
61 0 00c0ffee
62 0 00c0ffee
63 0 00c0ffee
64 0 00c0ffee
65 0 00c0ffee
66 0 00c0ffee
67 0 00c0ffee
512 0 00000000
1 1 00000000
5 1 12345678
8 1 12345678
13 1 87654321
30 1 87654321
64 1 0badcafe
70 0 0badcafe
509 0 5a5a0001
17 0 00000007
1 0 deadbeef
100 0 31415926
127 0 27182818
128 1 16180339

/* files.f */
verilog/xgmii_tx_pkg.sv
verilog/crc32_d64.sv
verilog/xgmii_tail_pack.sv
verilog/tx_frame_ctrl.sv
verilog/axis_xgmii_tx.sv
sim/tb_axis_xgmii_tx.sv

/* Bender.yml */
package:
  name: axis_xgmii_tx

sources:
  # package first, then the rtl bottom up
  - verilog/xgmii_tx_pkg.sv
  - verilog/crc32_d64.sv
  - verilog/xgmii_tail_pack.sv
  - verilog/tx_frame_ctrl.sv
  - verilog/axis_xgmii_tx.sv
  - target: test
    files:
      - sim/tb_axis_xgmii_tx.sv
